// ==== source/trace_pkg.sv ====
//////////////////////////////////////////////////
// Shared types for the pipeline trace unit
// Widths, observation and record structs, register map
// and the tracker state encoding, used by scoped names
//////////////////////////////////////////////////

package trace_pkg;

    typedef logic [31:0] word_t;     // Data word, counters, AXI data
    typedef logic [7:0]  seq_t;      // Sequence number, wraps at 256
    typedef logic [31:0] stamp_t;    // Cycles since reset
    typedef logic [7:0]  reg_addr_t; // AXI4-Lite register offset

    // Payload seen on the CPU stages in one cycle
    typedef struct packed {
        word_t fetch_pc;
        word_t decode_instr;
        word_t exec_result;
        word_t mem_addr;
        word_t wb_data;
    } pipe_obs_t;

    // One retired instruction
    typedef struct packed {
        seq_t   seq;
        word_t  pc;
        word_t  instr;
        word_t  result;
        word_t  mem_addr;
        word_t  wb_data;
        stamp_t stamp;
    } trace_rec_t;

    // Index 0 is fetch, 4 is write-back
    typedef struct packed {
        logic [4:0] valid;
        seq_t [4:0] seq;
    } stage_tags_t;

    typedef enum logic {
        trk_idle,
        trk_run
    } trk_state_e;

    //////////////////////////////////////////////////
    // Register offsets
    //////////////////////////////////////////////////
    localparam reg_addr_t REG_CTRL   = 8'h00; // Bit 0 enable
    localparam reg_addr_t REG_STATUS = 8'h04; // Level 5:0, overflow 8
    localparam reg_addr_t REG_RETIRED = 8'h08;
    localparam reg_addr_t REG_STALLS = 8'h0C;
    localparam reg_addr_t REG_SEQ    = 8'h10; // Head record fields from here
    localparam reg_addr_t REG_PC     = 8'h14;
    localparam reg_addr_t REG_INSTR  = 8'h18;
    localparam reg_addr_t REG_RESULT = 8'h1C;
    localparam reg_addr_t REG_MADDR  = 8'h20;
    localparam reg_addr_t REG_WBDATA = 8'h24;
    localparam reg_addr_t REG_STAMP  = 8'h28;
    localparam reg_addr_t REG_POP    = 8'h2C; // Write only

endpackage

// ==== source/stage_tag_tracker.sv ====
//////////////////////////////////////////////////
// Follows each instruction through the five CPU stages
// Numbers are handed out at fetch while running and
// shifted down under the CPU stall rule
//////////////////////////////////////////////////
`timescale 1ns/10ps

module stage_tag_tracker (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   enable,  // From control register
    input  logic                   stall,   // CPU stall, holds fetch and decode
    output trace_pkg::stage_tags_t tags
);

    trace_pkg::trk_state_e state;
    trace_pkg::seq_t       next_seq; // Number for the next fetch
    logic                  run;

    assign run = (state == trace_pkg::trk_run);

    // Run while enabled, otherwise let the stages drain
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= trace_pkg::trk_idle;
        end else begin
            case (state)
                trace_pkg::trk_idle: if (enable)  state <= trace_pkg::trk_run;
                trace_pkg::trk_run:  if (!enable) state <= trace_pkg::trk_idle;
                default:                          state <= trace_pkg::trk_idle;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Stage shift
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tags     <= '0;
            next_seq <= '0;
        end else begin
            if (!stall) begin
                tags.valid[0]   <= run;            // New fetch only when running
                tags.seq[0]     <= next_seq;
                tags.valid[2:1] <= tags.valid[1:0];
                tags.seq[2:1]   <= tags.seq[1:0];
                if (run) begin
                    next_seq <= next_seq + 1'b1;
                end
            end else begin
                // Fetch and decode hold, execute gets a bubble
                tags.valid[2] <= 1'b0;
            end
            tags.valid[4:3] <= tags.valid[3:2];    // Memory and WB always move
            tags.seq[4:3]   <= tags.seq[3:2];
        end
    end

    // Stalled front stages keep the same instructions across the next edge
    a_front_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(tags.valid[1:0]) && $stable(tags.seq[1:0]));

endmodule

// ==== source/trace_record_table.sv ====
//////////////////////////////////////////////////
// Builds one trace record per in-flight instruction
// Each stage writes its field while its tag is valid,
// write-back completes the record and pushes it out
//////////////////////////////////////////////////
`timescale 1ns/10ps

module trace_record_table #(
    parameter int TABLE_DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  trace_pkg::stage_tags_t tags,
    input  trace_pkg::pipe_obs_t   obs,
    output trace_pkg::trace_rec_t  rec,      // Finished record
    output logic                   rec_push  // One-cycle push strobe
);

    localparam int IDX_W = $clog2(TABLE_DEPTH);

    trace_pkg::trace_rec_t part [TABLE_DEPTH]; // Partial records by low seq bits
    trace_pkg::stamp_t     cycle_cnt;          // Free-running since reset
    logic [IDX_W-1:0]      idx [5];            // Table slot per stage

    always_comb begin
        for (int s = 0; s < 5; s++) begin
            idx[s] = tags.seq[s][IDX_W-1:0];
        end
    end

    //////////////////////////////////////////////////
    // Field capture, one stage per field
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (tags.valid[0]) begin
            part[idx[0]].seq <= tags.seq[0];
            part[idx[0]].pc  <= obs.fetch_pc; // Rewritten while fetch is stalled
        end
        if (tags.valid[1]) begin
            part[idx[1]].instr <= obs.decode_instr;
        end
        if (tags.valid[2]) begin
            part[idx[2]].result <= obs.exec_result;
        end
        if (tags.valid[3]) begin
            part[idx[3]].mem_addr <= obs.mem_addr;
        end
    end

    // Retirement, WB data and stamp come from this cycle
    always_ff @(posedge clk) begin
        if (tags.valid[4]) begin
            rec         <= part[idx[4]];
            rec.wb_data <= obs.wb_data;
            rec.stamp   <= cycle_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rec_push  <= 1'b0;
            cycle_cnt <= '0;
        end else begin
            rec_push  <= tags.valid[4];
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    // Oldest and youngest in flight must not share a slot
    a_table_room: assert property (@(posedge clk) disable iff (!rst_n)
        tags.valid[0] && tags.valid[4] |->
            trace_pkg::seq_t'(tags.seq[0] - tags.seq[4]) < TABLE_DEPTH);

endmodule

// ==== source/trace_fifo.sv ====
//////////////////////////////////////////////////
// Circular buffer of finished trace records
// Head is visible without popping, full drops pushes
//////////////////////////////////////////////////
`timescale 1ns/10ps

module trace_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  trace_pkg::trace_rec_t rec,
    input  logic                  push,
    input  logic                  pop,
    output trace_pkg::trace_rec_t head,     // Oldest record
    output logic [5:0]            level,    // Records stored
    output logic                  overflow  // Sticky until reset
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    trace_pkg::trace_rec_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic                  full;
    logic                  do_push;
    logic                  do_pop;

    assign full    = (level == 6'(FIFO_DEPTH));
    assign do_push = push && !full;
    assign do_pop  = pop && (level != '0); // Empty pop ignored
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= rec;
        end
    end

    //////////////////////////////////////////////////
    // Pointers and fill level
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            level    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1; // Wraps at depth
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
            if (push && full) begin
                overflow <= 1'b1;  // Record lost
            end
        end
    end

    a_level_cap: assert property (@(posedge clk) disable iff (!rst_n)
        level <= 6'(FIFO_DEPTH));

endmodule

// ==== source/trace_axil_regs.sv ====
//////////////////////////////////////////////////
// AXI4-Lite register block of the trace unit
// Control, status, counters, head record and pop command
//////////////////////////////////////////////////
`timescale 1ns/10ps

module trace_axil_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    // AXI4-Lite slave
    input  trace_pkg::reg_addr_t      s_axil_awaddr,
    input  logic                      s_axil_awvalid,
    output logic                      s_axil_awready,
    input  trace_pkg::word_t          s_axil_wdata,
    input  logic [3:0]                s_axil_wstrb,
    input  logic                      s_axil_wvalid,
    output logic                      s_axil_wready,
    output logic [1:0]                s_axil_bresp,
    output logic                      s_axil_bvalid,
    input  logic                      s_axil_bready,
    input  trace_pkg::reg_addr_t      s_axil_araddr,
    input  logic                      s_axil_arvalid,
    output logic                      s_axil_arready,
    output trace_pkg::word_t          s_axil_rdata,
    output logic [1:0]                s_axil_rresp,
    output logic                      s_axil_rvalid,
    input  logic                      s_axil_rready,
    // Trace side
    input  trace_pkg::trace_rec_t     head,
    input  logic [5:0]                level,
    input  logic                      overflow,
    input  logic                      rec_push,
    input  logic                      stall,
    output logic                      enable,
    output logic                      pop
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    trace_pkg::reg_addr_t aw_addr_q;  // Address held until the data arrives
    trace_pkg::word_t     wdata_q;
    logic [3:0]           wstrb_q;
    logic                 aw_got, w_got;
    logic                 aw_done, w_done, do_write;
    logic                 bvalid_nxt, rvalid_nxt;
    trace_pkg::reg_addr_t wr_addr;
    trace_pkg::word_t     wr_data;
    logic [3:0]           wr_strb;
    trace_pkg::word_t     retired_cnt;
    trace_pkg::word_t     stall_cnt;
    trace_pkg::word_t     rd_word;
    logic                 rd_ok;

    //////////////////////////////////////////////////
    // Write channel
    //////////////////////////////////////////////////
    assign aw_done  = aw_got || (s_axil_awvalid && s_axil_awready);
    assign w_done   = w_got || (s_axil_wvalid && s_axil_wready);
    assign do_write = aw_done && w_done;
    assign wr_addr  = aw_got ? aw_addr_q : s_axil_awaddr;
    assign wr_data  = w_got ? wdata_q : s_axil_wdata;
    assign wr_strb  = w_got ? wstrb_q : s_axil_wstrb;
    assign bvalid_nxt = do_write || (s_axil_bvalid && !s_axil_bready);

    always_ff @(posedge clk) begin
        if (s_axil_awvalid && s_axil_awready) aw_addr_q <= s_axil_awaddr;
        if (s_axil_wvalid && s_axil_wready) begin
            wdata_q <= s_axil_wdata;
            wstrb_q <= s_axil_wstrb;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            aw_got         <= 1'b0;
            w_got          <= 1'b0;
            s_axil_awready <= 1'b0;
            s_axil_wready  <= 1'b0;
            s_axil_bvalid  <= 1'b0;
            s_axil_bresp   <= RESP_OKAY;
            enable         <= 1'b0;
            pop            <= 1'b0;
        end else begin
            aw_got         <= aw_done && !do_write;
            w_got          <= w_done && !do_write;
            s_axil_awready <= !bvalid_nxt && !(aw_done && !do_write); // Closed while busy
            s_axil_wready  <= !bvalid_nxt && !(w_done && !do_write);
            s_axil_bvalid  <= bvalid_nxt;
            pop            <= do_write && (wr_addr == trace_pkg::REG_POP); // One pulse
            if (do_write) begin
                s_axil_bresp <= RESP_OKAY;
                case (wr_addr)
                    trace_pkg::REG_CTRL: if (wr_strb[0]) enable <= wr_data[0];
                    trace_pkg::REG_STATUS, trace_pkg::REG_RETIRED,
                    trace_pkg::REG_STALLS, trace_pkg::REG_POP: ;  // No effect here
                    default: if (wr_addr > trace_pkg::REG_STAMP ||
                                 wr_addr < trace_pkg::REG_SEQ) begin
                        s_axil_bresp <= RESP_SLVERR;
                    end
                endcase
            end
        end
    end

    // Event counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retired_cnt <= '0;
            stall_cnt   <= '0;
        end else begin
            if (rec_push)          retired_cnt <= retired_cnt + 1'b1;
            if (stall && enable)   stall_cnt   <= stall_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Read channel
    //////////////////////////////////////////////////
    always_comb begin
        rd_ok = 1'b1;
        case (s_axil_araddr)
            trace_pkg::REG_CTRL:    rd_word = {31'b0, enable};
            trace_pkg::REG_STATUS:  rd_word = {23'b0, overflow, 2'b0, level};
            trace_pkg::REG_RETIRED: rd_word = retired_cnt;
            trace_pkg::REG_STALLS:  rd_word = stall_cnt;
            trace_pkg::REG_SEQ:     rd_word = {24'b0, head.seq};
            trace_pkg::REG_PC:      rd_word = head.pc;
            trace_pkg::REG_INSTR:   rd_word = head.instr;
            trace_pkg::REG_RESULT:  rd_word = head.result;
            trace_pkg::REG_MADDR:   rd_word = head.mem_addr;
            trace_pkg::REG_WBDATA:  rd_word = head.wb_data;
            trace_pkg::REG_STAMP:   rd_word = head.stamp;
            trace_pkg::REG_POP:     rd_word = '0;    // Reads as zero
            default: begin
                rd_word = '0;
                rd_ok   = 1'b0;
            end
        endcase
    end

    assign rvalid_nxt = (s_axil_arvalid && s_axil_arready) ||
                        (s_axil_rvalid && !s_axil_rready);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s_axil_arready <= 1'b0;
            s_axil_rvalid  <= 1'b0;
            s_axil_rresp   <= RESP_OKAY;
            s_axil_rdata   <= '0;
        end else begin
            s_axil_arready <= !rvalid_nxt;  // One read outstanding
            s_axil_rvalid  <= rvalid_nxt;
            if (s_axil_arvalid && s_axil_arready) begin
                s_axil_rdata <= rd_word;
                s_axil_rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
            end
        end
    end

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid && $stable(s_axil_rdata));

endmodule

// ==== source/trace_unit_top.sv ====
//////////////////////////////////////////////////
// Pipeline trace unit top level
// Tracker, record table, record FIFO and AXI4-Lite registers
//////////////////////////////////////////////////
`timescale 1ns/10ps

module trace_unit_top #(
    parameter int TABLE_DEPTH = 8,   // Power of two, at least 8
    parameter int FIFO_DEPTH  = 16   // Power of two, at most 32
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  trace_pkg::pipe_obs_t obs,
    input  logic                 stall,
    input  trace_pkg::reg_addr_t s_axil_awaddr,
    input  logic                 s_axil_awvalid,
    output logic                 s_axil_awready,
    input  trace_pkg::word_t     s_axil_wdata,
    input  logic [3:0]           s_axil_wstrb,
    input  logic                 s_axil_wvalid,
    output logic                 s_axil_wready,
    output logic [1:0]           s_axil_bresp,
    output logic                 s_axil_bvalid,
    input  logic                 s_axil_bready,
    input  trace_pkg::reg_addr_t s_axil_araddr,
    input  logic                 s_axil_arvalid,
    output logic                 s_axil_arready,
    output trace_pkg::word_t     s_axil_rdata,
    output logic [1:0]           s_axil_rresp,
    output logic                 s_axil_rvalid,
    input  logic                 s_axil_rready
);

    trace_pkg::stage_tags_t tags;
    trace_pkg::trace_rec_t  rec, head;
    logic                   rec_push, pop, enable, overflow;
    logic [5:0]             level;

    stage_tag_tracker u_tracker (
        .clk, .rst_n, .enable, .stall, .tags
    );

    trace_record_table #(.TABLE_DEPTH(TABLE_DEPTH)) u_table (
        .clk, .rst_n, .tags, .obs, .rec, .rec_push
    );

    trace_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk, .rst_n, .rec, .push(rec_push), .pop, .head, .level, .overflow
    );

    trace_axil_regs u_regs (
        .clk, .rst_n,
        .s_axil_awaddr, .s_axil_awvalid, .s_axil_awready,
        .s_axil_wdata, .s_axil_wstrb, .s_axil_wvalid, .s_axil_wready,
        .s_axil_bresp, .s_axil_bvalid, .s_axil_bready,
        .s_axil_araddr, .s_axil_arvalid, .s_axil_arready,
        .s_axil_rdata, .s_axil_rresp, .s_axil_rvalid, .s_axil_rready,
        .head, .level, .overflow, .rec_push, .stall, .enable, .pop
    );

endmodule

// ==== testbench/tb_trace_unit.sv ====
//////////////////////////////////////////////////
// Testbench for the pipeline trace unit
// Stands in for the five-stage CPU, reads the trace records
// back over AXI4-Lite and checks them against payload formulas
//////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_trace_unit;

    localparam int TABLE_DEPTH = 8;
    localparam int FIFO_DEPTH  = 16;
    localparam int MAX_CYCLES  = 4000; // ~40 popped records at ~30 cycles each, plus runs

    logic                 clk = 1'b0;
    logic                 rst_n;
    trace_pkg::pipe_obs_t obs = '0;
    logic                 stall = 1'b0;
    trace_pkg::reg_addr_t s_axil_awaddr;
    logic                 s_axil_awvalid;
    logic                 s_axil_awready;
    trace_pkg::word_t     s_axil_wdata;
    logic [3:0]           s_axil_wstrb;
    logic                 s_axil_wvalid;
    logic                 s_axil_wready;
    logic [1:0]           s_axil_bresp;
    logic                 s_axil_bvalid;
    logic                 s_axil_bready;
    trace_pkg::reg_addr_t s_axil_araddr;
    logic                 s_axil_arvalid;
    logic                 s_axil_arready;
    trace_pkg::word_t     s_axil_rdata;
    logic [1:0]           s_axil_rresp;
    logic                 s_axil_rvalid;
    logic                 s_axil_rready;

    // CPU model, mirrors the enable register and the stage rules
    logic                 m_en;       // Enable as written over AXI
    logic                 m_run;      // Tracker running, one cycle behind m_en
    logic                 stall_on;   // Random stalls wanted
    logic [4:0]           m_valid;
    trace_pkg::seq_t      m_seq [5];
    trace_pkg::seq_t      m_next;
    int                   m_fetched;  // Instructions handed a number
    int                   m_stalls;   // Stall cycles seen while enabled
    int                   cycle_count = 0;

    int                   errors;
    int                   checks;
    int                   test_errors; // Error count at the start of a test
    trace_pkg::seq_t      exp_seq;     // Next record expected at the FIFO head
    trace_pkg::stamp_t    last_stamp;

    trace_unit_top #(.TABLE_DEPTH(TABLE_DEPTH), .FIFO_DEPTH(FIFO_DEPTH)) u_trace_unit_top (.*);

    always #5 clk = ~clk;

    // Payload of instruction n in each stage
    function automatic trace_pkg::word_t pc_of(input trace_pkg::seq_t n);
        return 32'h1000 + 4 * n;
    endfunction
    function automatic trace_pkg::word_t instr_of(input trace_pkg::seq_t n);
        return 32'(n) ^ 32'hA5A5_0000;
    endfunction
    function automatic trace_pkg::word_t result_of(input trace_pkg::seq_t n);
        return 32'(n) * 3;
    endfunction
    function automatic trace_pkg::word_t maddr_of(input trace_pkg::seq_t n);
        return 32'h8000 + n;
    endfunction
    function automatic trace_pkg::word_t wbdata_of(input trace_pkg::seq_t n);
        return 32'h5000 + n;
    endfunction

    //////////////////////////////////////////////////
    // CPU stand-in
    //////////////////////////////////////////////////
    always @(posedge clk) begin : cpu_model
        logic [4:0]      nv;
        trace_pkg::seq_t ns [5];
        nv = m_valid;
        ns = m_seq;
        if (!rst_n) begin
            m_run     <= 1'b0;
            m_valid   <= '0;
            m_next    <= '0;
            m_fetched <= 0;
            m_stalls  <= 0;
            stall     <= 1'b0;
        end else begin
            if (!stall) begin
                nv[2] = m_valid[1];          // Front stages advance
                ns[2] = m_seq[1];
                nv[1] = m_valid[0];
                ns[1] = m_seq[0];
                nv[0] = m_run;
                ns[0] = m_next;
                if (m_run) begin
                    m_next    <= m_next + 1'b1;
                    m_fetched <= m_fetched + 1;
                end
            end else begin
                nv[2] = 1'b0;                // Bubble into execute
            end
            nv[4] = m_valid[3];              // Memory and WB never stall
            ns[4] = m_seq[3];
            nv[3] = m_valid[2];
            ns[3] = m_seq[2];
            if (stall && m_en) m_stalls <= m_stalls + 1;
            m_run   <= m_en;
            m_valid <= nv;
            m_seq   <= ns;
            stall   <= stall_on && ($urandom() % 4 == 0); // About one cycle in four
        end
        obs.fetch_pc     <= pc_of(ns[0]);
        obs.decode_instr <= instr_of(ns[1]);
        obs.exec_result  <= result_of(ns[2]);
        obs.mem_addr     <= maddr_of(ns[3]);
        obs.wb_data      <= wbdata_of(ns[4]);
    end

    always @(posedge clk) begin : watchdog
        cycle_count <= cycle_count + 1;
        if (cycle_count == MAX_CYCLES) begin
            $display("Run stopped by timeout after %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Checks and AXI4-Lite master
    //////////////////////////////////////////////////
    task automatic expect_word(input string name, input trace_pkg::word_t got,
                               input trace_pkg::word_t exp);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic axi_write(input trace_pkg::reg_addr_t addr, input trace_pkg::word_t data);
        logic aw_ok;
        logic w_ok;
        aw_ok = 1'b0;
        w_ok  = 1'b0;
        s_axil_awaddr  <= addr;
        s_axil_awvalid <= 1'b1;
        s_axil_wdata   <= data;
        s_axil_wvalid  <= 1'b1;
        while (!(aw_ok && w_ok)) begin
            @(posedge clk);
            if (s_axil_awvalid && s_axil_awready) begin
                aw_ok = 1'b1;
                s_axil_awvalid <= 1'b0;
            end
            if (s_axil_wvalid && s_axil_wready) begin
                w_ok = 1'b1;
                s_axil_wvalid <= 1'b0;
            end
        end
        if (addr == trace_pkg::REG_CTRL) m_en <= data[0]; // Register takes it at this edge
        do @(posedge clk); while (!s_axil_bvalid);       // bready stays high
        expect_word("bresp", s_axil_bresp, 2'b00);
    endtask

    task automatic axi_read(input trace_pkg::reg_addr_t addr, output trace_pkg::word_t data,
                            output logic [1:0] resp);
        s_axil_araddr  <= addr;
        s_axil_arvalid <= 1'b1;
        s_axil_rready  <= 1'b0;                  // Slave has to hold its response
        do @(posedge clk); while (!s_axil_arready);
        s_axil_arvalid <= 1'b0;
        do @(posedge clk); while (!s_axil_rvalid);
        s_axil_rready <= 1'b1;                   // Taken one cycle late
        @(posedge clk);
        data = s_axil_rdata;
        resp = s_axil_rresp;
    endtask

    task automatic check_reg(input string name, input trace_pkg::reg_addr_t addr,
                             input trace_pkg::word_t exp);
        trace_pkg::word_t data;
        logic [1:0]       resp;
        axi_read(addr, data, resp);
        expect_word(name, data, exp);
        expect_word({name, " rresp"}, resp, 2'b00);
    endtask

    // Check the head record, then pop it
    task automatic pop_record();
        trace_pkg::word_t stamp;
        logic [1:0]       resp;
        check_reg("seq", trace_pkg::REG_SEQ, {24'b0, exp_seq});
        check_reg("pc", trace_pkg::REG_PC, pc_of(exp_seq));
        check_reg("instr", trace_pkg::REG_INSTR, instr_of(exp_seq));
        check_reg("result", trace_pkg::REG_RESULT, result_of(exp_seq));
        check_reg("mem_addr", trace_pkg::REG_MADDR, maddr_of(exp_seq));
        check_reg("wb_data", trace_pkg::REG_WBDATA, wbdata_of(exp_seq));
        axi_read(trace_pkg::REG_STAMP, stamp, resp);
        checks++;
        assert (stamp > last_stamp) else begin
            $display("Stamp %h of seq %0d does not follow %h", stamp, exp_seq, last_stamp);
            errors++;
        end
        last_stamp = stamp;
        axi_write(trace_pkg::REG_POP, 32'h0);
        exp_seq++;
    endtask

    // Three more fetches slip in while the disable write lands
    task automatic run_instructions(input int count, input logic with_stall);
        int start;
        start = m_fetched;
        stall_on <= with_stall;
        axi_write(trace_pkg::REG_CTRL, 32'h1);
        while (m_fetched - start < count - 3) @(posedge clk);
        axi_write(trace_pkg::REG_CTRL, 32'h0);
        stall_on <= 1'b0;
        do @(posedge clk); while (m_run || m_valid != '0); // Pipeline drained
    endtask

    task automatic wait_retired(input int expected);
        trace_pkg::word_t data;
        logic [1:0]       resp;
        int               polls;
        polls = 0;
        axi_read(trace_pkg::REG_RETIRED, data, resp);
        while (data != expected && polls < 20) begin
            axi_read(trace_pkg::REG_RETIRED, data, resp);
            polls++;
        end
        checks++;
        assert (data == expected) else begin
            $display("Retired count stuck at %0d, waited for %0d", data, expected);
            errors++;
        end
    endtask

    task automatic finish_test(input int num, input string name);
        if (errors == test_errors)
            $display("test %0d %s: passed", num, name);
        else
            $display("test %0d %s: FAILED with %0d errors", num, name, errors - test_errors);
        test_errors = errors;
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial begin : main
        trace_pkg::word_t data;
        logic [1:0]       resp;
        int               count;
        void'($urandom(32'h3b9e));
        rst_n          = 1'b0;
        m_en           = 1'b0;
        stall_on       = 1'b0;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = 4'hF;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b1;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b1;
        errors         = 0;
        checks         = 0;
        test_errors    = 0;
        exp_seq        = '0;
        last_stamp     = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        check_reg("status", trace_pkg::REG_STATUS, 32'h0);
        check_reg("ctrl", trace_pkg::REG_CTRL, 32'h0);
        stall_on <= 1'b1;                     // CPU busy, trace still off
        repeat (20) @(posedge clk);
        stall_on <= 1'b0;
        check_reg("retired", trace_pkg::REG_RETIRED, 32'h0);
        check_reg("stalls", trace_pkg::REG_STALLS, 32'h0);
        check_reg("status", trace_pkg::REG_STATUS, 32'h0);
        finish_test(1, "idle after reset");

        run_instructions(10, 1'b0);
        wait_retired(m_fetched);
        check_reg("status", trace_pkg::REG_STATUS, 32'd10);
        repeat (10) pop_record();
        check_reg("status", trace_pkg::REG_STATUS, 32'h0);
        finish_test(2, "ten instructions, no stall");

        count = m_fetched;
        run_instructions(12, 1'b1);
        wait_retired(m_fetched);
        repeat (m_fetched - count) pop_record();
        finish_test(3, "random stalls");

        check_reg("retired", trace_pkg::REG_RETIRED, m_fetched);
        check_reg("stalls", trace_pkg::REG_STALLS, m_stalls);
        expect_word("stall cycles seen", m_stalls != 0, 32'h1);
        finish_test(4, "counters");

        run_instructions(FIFO_DEPTH + 4, 1'b0);
        wait_retired(m_fetched);
        check_reg("status", trace_pkg::REG_STATUS, 32'h100 | FIFO_DEPTH); // Full, overflow set
        repeat (FIFO_DEPTH) pop_record();
        check_reg("status", trace_pkg::REG_STATUS, 32'h100);
        finish_test(5, "overflow");

        axi_read(8'h40, data, resp);
        expect_word("rresp", resp, 2'b10);
        axi_write(trace_pkg::REG_POP, 32'h0);
        check_reg("status", trace_pkg::REG_STATUS, 32'h100);
        finish_test(6, "unmapped read and empty pop");

        $display("6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
source/trace_pkg.sv
source/stage_tag_tracker.sv
source/trace_record_table.sv
source/trace_fifo.sv
source/trace_axil_regs.sv
source/trace_unit_top.sv
testbench/tb_trace_unit.sv
